//--- logic/frame_sequencer.sv
`timescale 1ns/10ps

module frame_sequencer #(
	parameter int EXT_FSYNC = 0
) (
	input  logic clk,
	input  logic resetn,
	input  logic fsync_i,
	input  logic m_tready_i,
	output logic m_tvalid_o,
	raster_if.sequencer scan
);
	import raster_pkg::*;

	seq_state_t state;
	logic armed;
	logic frame_go;
	logic frame_done;

	// Goes high one cycle after reset is released.
	always_ff @(posedge clk) begin
		if (!resetn)
			armed <= 1'b0;
		else
			armed <= 1'b1;
	end

	assign frame_go = (EXT_FSYNC != 0) ? fsync_i : armed;

	// Last pixel of the frame accepted, external mode only.
	assign frame_done = (EXT_FSYNC != 0) && m_tready_i && scan.frame_start_next;

	// At frame end the counter must stay on (0,0) for the next sync.
	always_comb begin
		if (state == ACTIVE)
			scan.advance = m_tready_i && !frame_done;
		else
			scan.advance = frame_go;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= IDLE;
			m_tvalid_o <= 1'b0;
		end else if (state == IDLE) begin
			if (frame_go) begin
				state <= ACTIVE;
				m_tvalid_o <= 1'b1;
			end
		end else if (frame_done) begin
			state <= IDLE;
			m_tvalid_o <= 1'b0;
		end
	end

	a_idle_no_valid: assert property (@(posedge clk) disable iff (!resetn)
		(state == IDLE) |-> !m_tvalid_o);

	a_no_advance_on_stall: assert property (@(posedge clk) disable iff (!resetn)
		(state == ACTIVE && !m_tready_i) |-> !scan.advance);

endmodule

//--- logic/raster_counter.sv
`timescale 1ns/10ps

module raster_counter (
	input  logic clk,
	input  logic resetn,
	input  logic [raster_pkg::coord_bits-1:0] width_i,
	input  logic [raster_pkg::coord_bits-1:0] height_i,
	raster_if.counter scan
);
	import raster_pkg::*;

	logic [coord_bits-1:0] col_q;
	logic [coord_bits-1:0] row_q;
	logic col_last;
	logic row_last;

	assign col_last = (col_q == width_i - 1'b1);
	assign row_last = (row_q == height_i - 1'b1);

	// Raster order, column first.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			col_q <= '0;
			row_q <= '0;
		end else if (scan.advance) begin
			if (col_last) begin
				col_q <= '0;
				if (row_last)
					row_q <= '0;
				else
					row_q <= row_q + 1'b1;
			end else begin
				col_q <= col_q + 1'b1;
			end
		end
	end

	assign scan.col_next = col_q;
	assign scan.row_next = row_q;
	assign scan.line_end_next = col_last;
	assign scan.frame_start_next = (col_q == '0) && (row_q == '0);

	a_pos_in_image: assert property (@(posedge clk) disable iff (!resetn)
		(col_q < width_i) && (row_q < height_i));

endmodule

//--- logic/raster_generator.sv
`timescale 1ns/10ps

module raster_generator #(
	parameter int WIN_NUM = 2,
	parameter int EXT_FSYNC = 0
) (
	input  logic clk,
	input  logic resetn,
	input  logic fsync_i,
	input  logic [raster_pkg::coord_bits-1:0] width_i,
	input  logic [raster_pkg::coord_bits-1:0] height_i,
	input  logic [raster_pkg::coord_bits-1:0] win_left_i [WIN_NUM],
	input  logic [raster_pkg::coord_bits-1:0] win_top_i [WIN_NUM],
	input  logic [raster_pkg::coord_bits-1:0] win_width_i [WIN_NUM],
	input  logic [raster_pkg::coord_bits-1:0] win_height_i [WIN_NUM],
	input  logic [WIN_NUM-1:0] win_dst_i [WIN_NUM],
	input  logic m_tready_i,
	output logic m_tvalid_o,
	output logic m_tlast_o,
	output logic [WIN_NUM:0] m_tuser_o
);
	import raster_pkg::*;

	logic [WIN_NUM-1:0] chan_flags;
	logic sof;

	if (WIN_NUM < 1 || WIN_NUM > max_windows) begin : g_bad_win_num
		$fatal(1, "raster_generator: WIN_NUM out of range");
	end

	raster_if scan ();

	frame_sequencer #(
		.EXT_FSYNC(EXT_FSYNC)
	) u_seq (
		.clk(clk),
		.resetn(resetn),
		.fsync_i(fsync_i),
		.m_tready_i(m_tready_i),
		.m_tvalid_o(m_tvalid_o),
		.scan(scan)
	);

	raster_counter u_cnt (
		.clk(clk),
		.resetn(resetn),
		.width_i(width_i),
		.height_i(height_i),
		.scan(scan)
	);

	window_flagger #(
		.WIN_NUM(WIN_NUM)
	) u_win (
		.clk(clk),
		.resetn(resetn),
		.win_left_i(win_left_i),
		.win_top_i(win_top_i),
		.win_width_i(win_width_i),
		.win_height_i(win_height_i),
		.win_dst_i(win_dst_i),
		.scan(scan),
		.chan_flags_o(chan_flags)
	);

	stream_marker u_mark (
		.clk(clk),
		.resetn(resetn),
		.m_tvalid_i(m_tvalid_o),
		.m_tready_i(m_tready_i),
		.scan(scan),
		.tlast_o(m_tlast_o),
		.sof_o(sof)
	);

	// Bit 0 is start of frame, channel flags above it.
	assign m_tuser_o = {chan_flags, sof};

	// While idle the scan always waits on pixel (0,0).
	a_idle_at_origin: assert property (@(posedge clk) disable iff (!resetn)
		(u_seq.state == IDLE) |-> scan.frame_start_next);

endmodule

//--- logic/raster_if.sv
`timescale 1ns/10ps

interface raster_if;
	import raster_pkg::*;

	// Pulses on each cycle where a new beat enters the output registers.
	logic advance;

	// Pixel that the next advance loads.
	logic [coord_bits-1:0] col_next;
	logic [coord_bits-1:0] row_next;
	logic line_end_next;
	logic frame_start_next;

	modport counter (
		input  advance,
		output col_next,
		output row_next,
		output line_end_next,
		output frame_start_next
	);

	modport sequencer (
		output advance,
		input  frame_start_next
	);

	modport flagger (
		input advance,
		input col_next,
		input row_next
	);

	modport marker (
		input advance,
		input line_end_next,
		input frame_start_next
	);

endinterface

//--- logic/raster_pkg.sv
package raster_pkg;

	// Largest number of windows, and so of output channels.
	localparam int max_windows = 8;

	// Bits in one column or row coordinate.
	localparam int coord_bits = 12;

	// Frame sequencer state.
	// In IDLE no beat is offered and the scan position rests on pixel (0,0).
	typedef enum logic {
		IDLE   = 1'b0,
		ACTIVE = 1'b1
	} seq_state_t;

endpackage

//--- logic/stream_marker.sv
`timescale 1ns/10ps

module stream_marker (
	input  logic clk,
	input  logic resetn,
	input  logic m_tvalid_i,
	input  logic m_tready_i,
	raster_if.marker scan,
	output logic tlast_o,
	output logic sof_o
);

	logic stalled;

	assign stalled = m_tvalid_i && !m_tready_i;

	// End of line and start of frame for the beat being loaded.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			tlast_o <= 1'b0;
			sof_o <= 1'b0;
		end else if (scan.advance) begin
			tlast_o <= scan.line_end_next;
			sof_o <= scan.frame_start_next;
		end
	end

	// Beat must not change under back-pressure.
	a_tlast_stable: assert property (@(posedge clk) disable iff (!resetn)
		stalled |=> $stable(tlast_o));

	a_sof_stable: assert property (@(posedge clk) disable iff (!resetn)
		stalled |=> $stable(sof_o));

endmodule

//--- logic/window_flagger.sv
`timescale 1ns/10ps

module window_flagger #(
	parameter int WIN_NUM = 2
) (
	input  logic clk,
	input  logic resetn,
	input  logic [raster_pkg::coord_bits-1:0] win_left_i [WIN_NUM],
	input  logic [raster_pkg::coord_bits-1:0] win_top_i [WIN_NUM],
	input  logic [raster_pkg::coord_bits-1:0] win_width_i [WIN_NUM],
	input  logic [raster_pkg::coord_bits-1:0] win_height_i [WIN_NUM],
	input  logic [WIN_NUM-1:0] win_dst_i [WIN_NUM],
	raster_if.flagger scan,
	output logic [WIN_NUM-1:0] chan_flags_o
);
	import raster_pkg::*;

	// One extra bit so left+width cannot wrap.
	logic [coord_bits:0] right_end [WIN_NUM];
	logic [coord_bits:0] bottom_end [WIN_NUM];
	logic [WIN_NUM-1:0] win_in;
	logic [WIN_NUM-1:0] chan_hit;

	for (genvar w = 0; w < WIN_NUM; w++) begin : g_win
		logic col_in;
		logic row_in;

		assign right_end[w] = win_left_i[w] + win_width_i[w];
		assign bottom_end[w] = win_top_i[w] + win_height_i[w];

		assign col_in = (scan.col_next >= win_left_i[w]) &&
			({1'b0, scan.col_next} < right_end[w]);
		assign row_in = (scan.row_next >= win_top_i[w]) &&
			({1'b0, scan.row_next} < bottom_end[w]);

		assign win_in[w] = col_in && row_in;
	end

	// A channel is hit if any covering window routes to it.
	always_comb begin
		chan_hit = '0;
		for (int w = 0; w < WIN_NUM; w++) begin
			if (win_in[w])
				chan_hit = chan_hit | win_dst_i[w];
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			chan_flags_o <= '0;
		else if (scan.advance)
			chan_flags_o <= chan_hit;
	end

	a_win_num_range: assert property (@(posedge clk)
		(WIN_NUM >= 1) && (WIN_NUM <= max_windows));

endmodule

//--- sources.f
+incdir+verification
logic/raster_pkg.sv
logic/raster_if.sv
logic/frame_sequencer.sv
logic/raster_counter.sv
logic/window_flagger.sv
logic/stream_marker.sv
logic/raster_generator.sv
verification/raster_tb.sv

//--- verification/raster_model.svh
`ifndef RASTER_MODEL_SVH
`define RASTER_MODEL_SVH

// Expected markers of any pixel.
// Uses img_width, win_cnt and the window table of the including module.

// Window w covers the pixel.
function automatic logic in_window(int col, int row, int w);
	logic col_hit;
	logic row_hit;
	col_hit = (col >= win_left[w]) && (col < win_left[w] + win_width[w]);
	row_hit = (row >= win_top[w]) && (row < win_top[w] + win_height[w]);
	return col_hit && row_hit;
endfunction

// End of line on the last column only.
function automatic logic expected_tlast(int col);
	return col == img_width - 1;
endfunction

// Bit 0 is start of frame, bit c+1 is channel c.
function automatic logic [win_cnt:0] expected_tuser(int col, int row);
	logic [win_cnt-1:0] chans;
	logic sof;
	chans = '0;
	for (int w = 0; w < win_cnt; w++) begin
		if (in_window(col, row, w))
			chans = chans | win_dst[w];
	end
	sof = (col == 0) && (row == 0);
	return {chans, sof};
endfunction

`endif

//--- verification/raster_tb.sv
`timescale 1ns/10ps

module raster_tb;
	import raster_pkg::*;

	localparam int img_width = 10;
	localparam int img_height = 6;
	localparam int win_cnt = 3;
	localparam int num_frames = 4;
	localparam int frame_beats = img_width * img_height;
	// Four frames need about 350 cycles at 70% ready, gaps add under 100.
	localparam int timeout_cycles = 3000;

	logic clk;
	logic resetn;
	logic fsync;
	logic ready;
	logic [coord_bits-1:0] width;
	logic [coord_bits-1:0] height;
	logic [coord_bits-1:0] win_left [win_cnt];
	logic [coord_bits-1:0] win_top [win_cnt];
	logic [coord_bits-1:0] win_width [win_cnt];
	logic [coord_bits-1:0] win_height [win_cnt];
	logic [win_cnt-1:0] win_dst [win_cnt];

	logic ext_valid;
	logic ext_tlast;
	logic [win_cnt:0] ext_tuser;
	logic free_valid;
	logic free_tlast;
	logic [win_cnt:0] free_tuser;

	// Reference state of both streams.
	logic ext_active;
	logic free_armed;
	logic free_active;
	int ext_col;
	int ext_row;
	int free_col;
	int free_row;
	int ext_frames;
	int free_beats;
	int cycle_count;
	int gap_len [num_frames];

	`include "raster_model.svh"

	raster_generator #(
		.WIN_NUM(win_cnt),
		.EXT_FSYNC(1)
	) uut (
		.clk(clk),
		.resetn(resetn),
		.fsync_i(fsync),
		.width_i(width),
		.height_i(height),
		.win_left_i(win_left),
		.win_top_i(win_top),
		.win_width_i(win_width),
		.win_height_i(win_height),
		.win_dst_i(win_dst),
		.m_tready_i(ready),
		.m_tvalid_o(ext_valid),
		.m_tlast_o(ext_tlast),
		.m_tuser_o(ext_tuser)
	);

	raster_generator #(
		.WIN_NUM(win_cnt),
		.EXT_FSYNC(0)
	) uut_free (
		.clk(clk),
		.resetn(resetn),
		.fsync_i(fsync),
		.width_i(width),
		.height_i(height),
		.win_left_i(win_left),
		.win_top_i(win_top),
		.win_width_i(win_width),
		.win_height_i(win_height),
		.win_dst_i(win_dst),
		.m_tready_i(ready),
		.m_tvalid_o(free_valid),
		.m_tlast_o(free_tlast),
		.m_tuser_o(free_tuser)
	);

	task automatic stop_run();
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped on error.");
	endtask

	task automatic check_equal(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, exp);
			stop_run();
		end
	endtask

	// Raster order, column first.
	task automatic step_raster(inout int col, inout int row);
		col++;
		if (col == img_width) begin
			col = 0;
			row = (row == img_height - 1) ? 0 : row + 1;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// All random numbers come from this process.
	initial begin
		void'($urandom(73));
		for (int f = 0; f < num_frames; f++)
			gap_len[f] = 1 + $urandom % 20;
		forever begin
			@(negedge clk);
			ready = ($urandom % 100) < 70;
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: the frames did not finish within %0d cycles.", timeout_cycles);
			stop_run();
		end
	end

	// Outputs are read before the DUT registers update on this edge.
	always @(posedge clk) begin
		if (resetn) begin
			check_equal("uut.m_tvalid_o", ext_valid, ext_active);
			if (ext_valid) begin
				check_equal("uut.m_tlast_o", ext_tlast, expected_tlast(ext_col));
				check_equal("uut.m_tuser_o", ext_tuser, expected_tuser(ext_col, ext_row));
			end
			if (ext_active && ready) begin
				if (ext_col == img_width - 1 && ext_row == img_height - 1) begin
					ext_active = 1'b0;
					ext_frames++;
				end
				step_raster(ext_col, ext_row);
			end else if (!ext_active && fsync) begin
				ext_active = 1'b1;
			end

			check_equal("uut_free.m_tvalid_o", free_valid, free_active);
			if (free_valid) begin
				check_equal("uut_free.m_tlast_o", free_tlast, expected_tlast(free_col));
				check_equal("uut_free.m_tuser_o", free_tuser,
					expected_tuser(free_col, free_row));
			end
			if (free_active && ready) begin
				free_beats++;
				step_raster(free_col, free_row);
			end
			// Free stream starts on the second edge after reset.
			if (free_armed)
				free_active = 1'b1;
			free_armed = 1'b1;
		end
	end

	initial begin
		resetn = 1'b0;
		fsync = 1'b0;
		ready = 1'b0;
		width = img_width;
		height = img_height;
		// Overlap at columns 3..4, rows 2..3.
		win_left[0] = 1;
		win_top[0] = 1;
		win_width[0] = 4;
		win_height[0] = 3;
		win_dst[0] = 3'b001;
		win_left[1] = 3;
		win_top[1] = 2;
		win_width[1] = 4;
		win_height[1] = 3;
		win_dst[1] = 3'b110;
		// Touches the right edge.
		win_left[2] = 7;
		win_top[2] = 0;
		win_width[2] = 3;
		win_height[2] = 6;
		win_dst[2] = 3'b100;
		ext_active = 1'b0;
		free_armed = 1'b0;
		free_active = 1'b0;
		ext_col = 0;
		ext_row = 0;
		free_col = 0;
		free_row = 0;
		ext_frames = 0;
		free_beats = 0;

		repeat (4) @(posedge clk);
		@(negedge clk);
		check_equal("uut.m_tvalid_o", ext_valid, 1'b0);
		check_equal("uut.m_tlast_o", ext_tlast, 1'b0);
		check_equal("uut.m_tuser_o", ext_tuser, '0);
		check_equal("uut_free.m_tvalid_o", free_valid, 1'b0);
		check_equal("uut_free.m_tlast_o", free_tlast, 1'b0);
		check_equal("uut_free.m_tuser_o", free_tuser, '0);
		resetn = 1'b1;

		// No sync yet, so uut stays idle.
		repeat (10) @(negedge clk);
		for (int f = 0; f < num_frames; f++) begin
			repeat (gap_len[f]) @(negedge clk);
			fsync = 1'b1;
			@(negedge clk);
			fsync = 1'b0;
			if (f == 1) begin
				// Mid-frame pulse.
				repeat (15) @(negedge clk);
				fsync = 1'b1;
				@(negedge clk);
				fsync = 1'b0;
			end
			while (ext_frames < f + 1)
				@(negedge clk);
		end
		repeat (10) @(negedge clk);

		if (ext_frames == num_frames && free_beats > frame_beats) begin
			$display(">>> PASS");
			$finish;
		end else begin
			$display("Run ended with too few frames or free-running beats.");
			stop_run();
		end
	end

endmodule
